//--- src/mm_types_pkg.sv
`default_nettype none

package mm_types_pkg;

  // matrix dimension, legal range 1..8
  typedef logic [3:0] dim_t;

  // one packed data lane
  typedef logic [7:0] byte_t;

  typedef logic signed [31:0] result_t;

  // one memory word, read either as byte lanes or as command fields
  typedef union packed {
    byte_t [3:0] lanes;  // lane 0 holds the lowest matrix index
    struct packed {
      logic [15:0] hi;   // p in command word 1
      logic [15:0] lo;   // m in word 1, n in word 2
    } dims;
  } mem_word_u;

endpackage

`default_nettype wire

//--- src/mm_map_pkg.sv
`default_nettype none

package mm_map_pkg;

  typedef logic [7:0] addr_t;  // word address

  localparam int MEM_WORDS = 256;

  // data regions
  localparam addr_t FM_BASE  = 8'd0;    // column-major feature words
  localparam addr_t WM_BASE  = 8'd32;   // row-major weight words
  localparam addr_t OUT_BASE = 8'd128;  // results, row-major

  // control words
  localparam addr_t ADDR_COM1 = 8'd64;  // m and p
  localparam addr_t ADDR_COM2 = 8'd65;  // n
  localparam addr_t ADDR_FLAG = 8'd66;

  localparam logic [31:0] FLAG_START  = 32'd1;
  localparam logic [31:0] FLAG_FINISH = 32'd2;

endpackage

`default_nettype wire

//--- src/shared_ram.sv
`timescale 1ns/1ps
`default_nettype none

module shared_ram (
  input  wire                          arm_clk,
  input  wire                          we,
  input  wire mm_map_pkg::addr_t       addr,
  input  wire mm_types_pkg::mem_word_u wdata,
  output mm_types_pkg::mem_word_u      rdata
);

  mm_types_pkg::mem_word_u mem [mm_map_pkg::MEM_WORDS];

  always_ff @(posedge arm_clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];  // read-first, one cycle latency
  end

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire                          arm_clk,
  input  wire                          rst,
  input  wire                          host_req,
  input  wire                          host_we,
  input  wire mm_map_pkg::addr_t       host_addr,
  input  wire mm_types_pkg::mem_word_u host_wdata,
  input  wire                          eng_req,
  input  wire                          eng_we,
  input  wire mm_map_pkg::addr_t       eng_addr,
  input  wire mm_types_pkg::mem_word_u eng_wdata,
  output logic                         host_gnt,
  output logic                         eng_gnt,
  output mm_types_pkg::mem_word_u      host_rdata,
  output mm_types_pkg::mem_word_u      eng_rdata,
  output logic                         ram_we,
  output mm_map_pkg::addr_t            ram_addr,
  output mm_types_pkg::mem_word_u      ram_wdata,
  input  wire mm_types_pkg::mem_word_u ram_rdata
);

  logic host_rd;  // pending read belongs to host
  logic eng_rd;

  // host always first
  assign host_gnt = host_req;
  assign eng_gnt  = eng_req & ~host_req;

  assign ram_we    = host_gnt ? host_we : (eng_gnt & eng_we);
  assign ram_addr  = host_req ? host_addr : eng_addr;
  assign ram_wdata = host_req ? host_wdata : eng_wdata;

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      host_rd <= 1'b0;
      eng_rd  <= 1'b0;
    end else begin
      host_rd <= host_gnt & ~host_we;
      eng_rd  <= eng_gnt & ~eng_we;
    end
  end

  // returned word only shows up on the side that asked
  assign host_rdata = host_rd ? ram_rdata : '0;
  assign eng_rdata  = eng_rd ? ram_rdata : '0;

  // a losing engine request stays put until granted
  a_eng_held: assert property (@(posedge arm_clk) disable iff (rst)
    (eng_req && !eng_gnt) |=>
      (eng_req && $stable(eng_addr) && $stable(eng_we)))
    else $error("engine request dropped before grant");

endmodule

`default_nettype wire

//--- src/host_seq.sv
`timescale 1ns/1ps
`default_nettype none

module host_seq #(
  parameter int POLL_INTERVAL = 16
) (
  input  wire                          arm_clk,
  input  wire                          rst,
  input  wire                          job_valid,
  input  wire mm_types_pkg::dim_t      job_m,
  input  wire mm_types_pkg::dim_t      job_n,
  input  wire mm_types_pkg::dim_t      job_p,
  input  wire                          data_valid,
  input  wire mm_types_pkg::mem_word_u data_word,
  output logic                         busy,
  output logic                         done,
  output logic                         result_valid,
  output mm_types_pkg::result_t        result_data,
  output logic                         mem_req,
  output logic                         mem_we,
  output mm_map_pkg::addr_t            mem_addr,
  output mm_types_pkg::mem_word_u      mem_wdata,
  input  wire mm_types_pkg::mem_word_u mem_rdata
);

  localparam logic [7:0] IDLE       = 8'b0000_0001;
  localparam logic [7:0] LOAD_FM    = 8'b0000_0010;
  localparam logic [7:0] LOAD_WM    = 8'b0000_0100;
  localparam logic [7:0] WRITE_COM  = 8'b0000_1000;
  localparam logic [7:0] WRITE_FLAG = 8'b0001_0000;
  localparam logic [7:0] WAIT_FLAG  = 8'b0010_0000;
  localparam logic [7:0] READ_OUT   = 8'b0100_0000;
  localparam logic [7:0] FINISH     = 8'b1000_0000;

  logic [7:0]              state;
  logic [7:0]              cnt;
  mm_types_pkg::dim_t      m, n, p;
  logic [7:0]              m8, n8, p8;
  logic [7:0]              fm_words, wm_words, out_words;
  logic [15:0]             poll_timer;
  logic                    poll_tick;
  logic                    issue_wr, issue_rd;
  mm_map_pkg::addr_t       nxt_addr;
  mm_types_pkg::mem_word_u nxt_wdata;
  logic                    out_req;  // read in flight is a result read
  logic                    rd_out;
  logic                    poll_rd;  // flag word on mem_rdata this cycle

  assign m8 = {4'd0, m};
  assign n8 = {4'd0, n};
  assign p8 = {4'd0, p};

  // four lanes per word, rounded up
  assign fm_words  = n8 * ((m8 + 8'd3) >> 2);
  assign wm_words  = n8 * ((p8 + 8'd3) >> 2);
  assign out_words = m8 * p8;

  assign poll_tick = (poll_timer == 16'(POLL_INTERVAL - 1));

  always_comb begin
    issue_wr  = 1'b0;
    issue_rd  = 1'b0;
    nxt_addr  = mm_map_pkg::ADDR_FLAG;
    nxt_wdata = data_word;
    case (state)
      LOAD_FM: begin
        issue_wr = data_valid;
        nxt_addr = mm_map_pkg::FM_BASE + cnt;
      end
      LOAD_WM: begin
        issue_wr = data_valid;
        nxt_addr = mm_map_pkg::WM_BASE + cnt;
      end
      WRITE_COM: begin
        issue_wr = 1'b1;
        nxt_addr = (cnt == 8'd0) ? mm_map_pkg::ADDR_COM1 : mm_map_pkg::ADDR_COM2;
        nxt_wdata.dims.hi = (cnt == 8'd0) ? 16'(p) : 16'd0;
        nxt_wdata.dims.lo = (cnt == 8'd0) ? 16'(m) : 16'(n);
      end
      WRITE_FLAG: begin
        issue_wr  = 1'b1;
        nxt_wdata = mm_types_pkg::mem_word_u'(mm_map_pkg::FLAG_START);
      end
      WAIT_FLAG: issue_rd = poll_tick;
      READ_OUT: begin
        issue_rd = 1'b1;
        nxt_addr = mm_map_pkg::OUT_BASE + cnt;
      end
      default: ;
    endcase
  end

  // address and data follow the request flop
  always_ff @(posedge arm_clk) begin
    mem_addr  <= nxt_addr;
    mem_wdata <= nxt_wdata;
  end

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      state      <= IDLE;
      cnt        <= 8'd0;
      m          <= '0;
      n          <= '0;
      p          <= '0;
      poll_timer <= 16'd0;
      mem_req    <= 1'b0;
      mem_we     <= 1'b0;
      out_req    <= 1'b0;
      rd_out     <= 1'b0;
      poll_rd    <= 1'b0;
      busy       <= 1'b0;
      done       <= 1'b0;
    end else begin
      mem_req <= issue_wr | issue_rd;
      mem_we  <= issue_wr;
      out_req <= issue_rd && (state == READ_OUT);
      rd_out  <= out_req;
      poll_rd <= mem_req && !mem_we && !out_req;
      done    <= 1'b0;
      case (state)
        IDLE: begin
          if (job_valid) begin
            m     <= job_m;
            n     <= job_n;
            p     <= job_p;
            cnt   <= 8'd0;
            busy  <= 1'b1;
            state <= LOAD_FM;
          end
        end
        LOAD_FM: begin
          if (data_valid) begin
            cnt <= (cnt == fm_words - 8'd1) ? 8'd0 : cnt + 8'd1;
            if (cnt == fm_words - 8'd1) state <= LOAD_WM;
          end
        end
        LOAD_WM: begin
          if (data_valid) begin
            cnt <= (cnt == wm_words - 8'd1) ? 8'd0 : cnt + 8'd1;
            if (cnt == wm_words - 8'd1) state <= WRITE_COM;
          end
        end
        WRITE_COM: begin
          cnt <= (cnt == 8'd1) ? 8'd0 : cnt + 8'd1;
          if (cnt == 8'd1) state <= WRITE_FLAG;
        end
        WRITE_FLAG: begin
          poll_timer <= 16'd0;
          state      <= WAIT_FLAG;
        end
        WAIT_FLAG: begin
          poll_timer <= poll_tick ? 16'd0 : poll_timer + 16'd1;
          if (poll_rd && mem_rdata == mm_map_pkg::FLAG_FINISH) begin
            cnt   <= 8'd0;
            state <= READ_OUT;
          end
        end
        READ_OUT: begin
          cnt <= (cnt == out_words - 8'd1) ? 8'd0 : cnt + 8'd1;
          if (cnt == out_words - 8'd1) state <= FINISH;
        end
        FINISH: begin
          // last result on the port now
          if (rd_out && !out_req) begin
            done  <= 1'b1;
            busy  <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign result_valid = rd_out;
  assign result_data  = mm_types_pkg::result_t'(mem_rdata);

  a_dims_ok: assert property (@(posedge arm_clk) disable iff (rst)
    (state == IDLE && job_valid) |->
      (job_m inside {[4'd1:4'd8]} && job_n inside {[4'd1:4'd8]} &&
       job_p inside {[4'd1:4'd8]}))
    else $error("job dimensions out of range");

endmodule

`default_nettype wire

//--- src/mm_engine.sv
`timescale 1ns/1ps
`default_nettype none

module mm_engine (
  input  wire                          arm_clk,
  input  wire                          rst,
  output logic                         mem_req,
  output logic                         mem_we,
  output mm_map_pkg::addr_t            mem_addr,
  output mm_types_pkg::mem_word_u      mem_wdata,
  input  wire                          mem_gnt,
  input  wire mm_types_pkg::mem_word_u mem_rdata
);

  localparam logic [7:0] IDLE  = 8'b0000_0001;
  localparam logic [7:0] POLL  = 8'b0000_0010;
  localparam logic [7:0] CMD1  = 8'b0000_0100;
  localparam logic [7:0] CMD2  = 8'b0000_1000;
  localparam logic [7:0] FEAT  = 8'b0001_0000;
  localparam logic [7:0] WGT   = 8'b0010_0000;
  localparam logic [7:0] WRITE = 8'b0100_0000;
  localparam logic [7:0] FIN   = 8'b1000_0000;

  logic [7:0]            state;
  logic                  pend;  // granted read, data arrives now
  mm_types_pkg::dim_t    m, n, p;
  mm_types_pkg::dim_t    i, j, k;
  logic [7:0]            i8, j8, k8, p8;
  logic [7:0]            m_grp, p_grp;
  mm_types_pkg::byte_t   fbyte;
  mm_types_pkg::result_t acc;
  mm_types_pkg::result_t prod;
  logic signed [8:0]     f_s;
  logic signed [7:0]     w_s;

  assign i8    = {4'd0, i};
  assign j8    = {4'd0, j};
  assign k8    = {4'd0, k};
  assign p8    = {4'd0, p};
  assign m_grp = ({4'd0, m} + 8'd3) >> 2;
  assign p_grp = (p8 + 8'd3) >> 2;

  // feature byte is unsigned, weight byte signed
  assign f_s  = {1'b0, fbyte};
  assign w_s  = mem_rdata.lanes[j[1:0]];
  assign prod = f_s * w_s;

  always_comb begin
    mem_req   = 1'b0;
    mem_we    = 1'b0;
    mem_addr  = mm_map_pkg::ADDR_FLAG;
    mem_wdata = mm_types_pkg::mem_word_u'(acc);
    case (state)
      POLL: mem_req = !pend;
      CMD1: begin
        mem_req  = !pend;
        mem_addr = mm_map_pkg::ADDR_COM1;
      end
      CMD2: begin
        mem_req  = !pend;
        mem_addr = mm_map_pkg::ADDR_COM2;
      end
      FEAT: begin
        mem_req  = !pend;
        mem_addr = mm_map_pkg::FM_BASE + k8 * m_grp + (i8 >> 2);  // column k, group of i
      end
      WGT: begin
        mem_req  = !pend;
        mem_addr = mm_map_pkg::WM_BASE + k8 * p_grp + (j8 >> 2);  // row k, group of j
      end
      WRITE: begin
        mem_req  = 1'b1;
        mem_we   = 1'b1;
        mem_addr = mm_map_pkg::OUT_BASE + i8 * p8 + j8;
      end
      FIN: begin
        mem_req   = 1'b1;
        mem_we    = 1'b1;
        mem_wdata = mm_types_pkg::mem_word_u'(mm_map_pkg::FLAG_FINISH);
      end
      default: ;
    endcase
  end

  always_ff @(posedge arm_clk) begin
    if (pend && state == FEAT) fbyte <= mem_rdata.lanes[i[1:0]];
    if (pend && state == WGT) begin
      acc <= acc + prod;
    end else if (state == CMD2 || (state == WRITE && mem_gnt)) begin
      acc <= '0;  // fresh sum per (i, j)
    end
  end

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
      pend  <= 1'b0;
      m     <= '0;
      n     <= '0;
      p     <= '0;
      i     <= '0;
      j     <= '0;
      k     <= '0;
    end else begin
      if (mem_req && !mem_we && mem_gnt) pend <= 1'b1;
      case (state)
        IDLE: state <= POLL;  // one quiet cycle between polls
        POLL: begin
          if (pend) begin
            pend  <= 1'b0;
            state <= (mem_rdata == mm_map_pkg::FLAG_START) ? CMD1 : IDLE;
          end
        end
        CMD1: begin
          if (pend) begin
            pend  <= 1'b0;
            m     <= mem_rdata.dims.lo[3:0];
            p     <= mem_rdata.dims.hi[3:0];
            state <= CMD2;
          end
        end
        CMD2: begin
          if (pend) begin
            pend  <= 1'b0;
            n     <= mem_rdata.dims.lo[3:0];
            i     <= '0;
            j     <= '0;
            k     <= '0;
            state <= FEAT;
          end
        end
        FEAT: begin
          if (pend) begin
            pend  <= 1'b0;
            state <= WGT;
          end
        end
        WGT: begin
          if (pend) begin
            pend  <= 1'b0;
            k     <= (k == n - 4'd1) ? '0 : k + 4'd1;
            state <= (k == n - 4'd1) ? WRITE : FEAT;
          end
        end
        WRITE: begin
          if (mem_gnt) begin
            if (j == p - 4'd1) begin
              j     <= '0;
              i     <= i + 4'd1;
              state <= (i == m - 4'd1) ? FIN : FEAT;
            end else begin
              j     <= j + 4'd1;
              state <= FEAT;
            end
          end
        end
        FIN: if (mem_gnt) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  a_addr_in_region: assert property (@(posedge arm_clk) disable iff (rst)
    mem_req |->
      ((state == FEAT) ? (mem_addr < mm_map_pkg::WM_BASE) :
       (state == WGT)  ? (mem_addr >= mm_map_pkg::WM_BASE &&
                          mem_addr < mm_map_pkg::ADDR_COM1) :
       (state == WRITE) ? (mem_addr >= mm_map_pkg::OUT_BASE) : 1'b1))
    else $error("engine address outside its region");

endmodule

`default_nettype wire

//--- src/mm_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mm_sys_top #(
  parameter int POLL_INTERVAL = 16
) (
  input  wire                          arm_clk,
  input  wire                          rst,
  input  wire                          job_valid,
  input  wire mm_types_pkg::dim_t      job_m,
  input  wire mm_types_pkg::dim_t      job_n,
  input  wire mm_types_pkg::dim_t      job_p,
  input  wire                          data_valid,
  input  wire mm_types_pkg::mem_word_u data_word,
  output logic                         result_valid,
  output mm_types_pkg::result_t        result_data,
  output logic                         busy,
  output logic                         done
);

  // host side
  logic                    host_req, host_we;
  mm_map_pkg::addr_t       host_addr;
  mm_types_pkg::mem_word_u host_wdata, host_rdata;

  // engine side
  logic                    eng_req, eng_we, eng_gnt;
  mm_map_pkg::addr_t       eng_addr;
  mm_types_pkg::mem_word_u eng_wdata, eng_rdata;

  // memory port
  logic                    ram_we;
  mm_map_pkg::addr_t       ram_addr;
  mm_types_pkg::mem_word_u ram_wdata, ram_rdata;

  host_seq #(.POLL_INTERVAL(POLL_INTERVAL)) u_host (
    .arm_clk(arm_clk), .rst(rst),
    .job_valid(job_valid), .job_m(job_m), .job_n(job_n), .job_p(job_p),
    .data_valid(data_valid), .data_word(data_word),
    .busy(busy), .done(done),
    .result_valid(result_valid), .result_data(result_data),
    .mem_req(host_req), .mem_we(host_we), .mem_addr(host_addr),
    .mem_wdata(host_wdata), .mem_rdata(host_rdata)
  );

  mm_engine u_engine (
    .arm_clk(arm_clk), .rst(rst),
    .mem_req(eng_req), .mem_we(eng_we), .mem_addr(eng_addr),
    .mem_wdata(eng_wdata), .mem_gnt(eng_gnt), .mem_rdata(eng_rdata)
  );

  // host never waits, so its grant stays inside the arbiter
  mem_arbiter u_arb (
    .arm_clk(arm_clk), .rst(rst),
    .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
    .host_wdata(host_wdata),
    .eng_req(eng_req), .eng_we(eng_we), .eng_addr(eng_addr), .eng_wdata(eng_wdata),
    .host_gnt(), .eng_gnt(eng_gnt),
    .host_rdata(host_rdata), .eng_rdata(eng_rdata),
    .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
  );

  shared_ram u_ram (
    .arm_clk(arm_clk),
    .we(ram_we),
    .addr(ram_addr),
    .wdata(ram_wdata),
    .rdata(ram_rdata)
  );

endmodule

`default_nettype wire

//--- bench/tb_mm_sys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mm_sys;

  localparam int NUM_JOBS    = 20;
  localparam int JOB_TIMEOUT = 20000;  // cycles allowed per job

  logic                    arm_clk;
  logic                    rst;
  logic                    job_valid;
  mm_types_pkg::dim_t      job_m;
  mm_types_pkg::dim_t      job_n;
  mm_types_pkg::dim_t      job_p;
  logic                    data_valid;
  mm_types_pkg::mem_word_u data_word;
  logic                    result_valid;
  mm_types_pkg::result_t   result_data;
  logic                    busy;
  logic                    done;

  logic [31:0]             lfsr_state;
  mm_types_pkg::byte_t     feat [8][8];  // [i][k], unsigned bytes
  mm_types_pkg::byte_t     wgt  [8][8];  // [k][j], signed bytes
  mm_types_pkg::result_t   expected [$];

  mm_sys_top uut (
    .arm_clk(arm_clk), .rst(rst),
    .job_valid(job_valid), .job_m(job_m), .job_n(job_n), .job_p(job_p),
    .data_valid(data_valid), .data_word(data_word),
    .result_valid(result_valid), .result_data(result_data),
    .busy(busy), .done(done)
  );

  always #4 arm_clk = ~arm_clk;

  // x^32 + x^22 + x^2 + x + 1 in right-shifting form
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < nbits; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};  // one step per bit
    end
    return r;
  endfunction

  task automatic report_error(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_result(input mm_types_pkg::result_t got,
                              input mm_types_pkg::result_t exp, input int idx);
    if (got !== exp) begin
      report_error($sformatf("CHECK FAILED at %0t: result_data[%0d] got %0d expected %0d",
                             $time, idx, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_error($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                             $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                             $time, name, got, exp));
    end
  endtask

  task automatic check_idle();
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("result_valid", result_valid, 1'b0);
  endtask

  task automatic start_job(input int m, input int n, input int p);
    @(posedge arm_clk);
    #1;
    job_m     = mm_types_pkg::dim_t'(m);
    job_n     = mm_types_pkg::dim_t'(n);
    job_p     = mm_types_pkg::dim_t'(p);
    job_valid = 1'b1;
    @(posedge arm_clk);
    #1;
    job_valid = 1'b0;
    check_flag("busy", busy, 1'b1);  // accepted on that edge
  endtask

  task automatic send_word(input mm_types_pkg::mem_word_u w);
    if (rand_bits(2) == 32'd0) begin  // occasional idle cycle
      @(posedge arm_clk);
      #1;
    end
    data_valid = 1'b1;
    data_word  = w;
    @(posedge arm_clk);
    #1;
    data_valid = 1'b0;
  endtask

  // whole words are random so unused lanes carry garbage
  task automatic load_matrices(input int m, input int n, input int p);
    mm_types_pkg::mem_word_u w;
    int groups;
    groups = (m + 3) / 4;
    for (int k = 0; k < n; k++) begin
      for (int g = 0; g < groups; g++) begin
        w = mm_types_pkg::mem_word_u'(rand_bits(32));
        for (int l = 0; l < 4; l++) begin
          if (4 * g + l < m) feat[4 * g + l][k] = w.lanes[l];
        end
        send_word(w);
      end
    end
    groups = (p + 3) / 4;
    for (int k = 0; k < n; k++) begin
      for (int g = 0; g < groups; g++) begin
        w = mm_types_pkg::mem_word_u'(rand_bits(32));
        for (int l = 0; l < 4; l++) begin
          if (4 * g + l < p) wgt[k][4 * g + l] = w.lanes[l];
        end
        send_word(w);
      end
    end
  endtask

  // sum over k of unsigned feature times signed weight
  function automatic void build_expected(input int m, input int n, input int p);
    mm_types_pkg::result_t acc;
    expected.delete();
    for (int i = 0; i < m; i++) begin
      for (int j = 0; j < p; j++) begin
        acc = '0;
        for (int k = 0; k < n; k++) begin
          acc = acc + int'(feat[i][k]) * int'($signed(wgt[k][j]));
        end
        expected.push_back(acc);
      end
    end
  endfunction

  // a second command while busy must be dropped
  task automatic ignored_job();
    check_flag("busy", busy, 1'b1);
    job_m     = mm_types_pkg::dim_t'(rand_bits(3) + 32'd1);
    job_n     = mm_types_pkg::dim_t'(rand_bits(3) + 32'd1);
    job_p     = mm_types_pkg::dim_t'(rand_bits(3) + 32'd1);
    job_valid = 1'b1;
    @(posedge arm_clk);
    #1;
    job_valid = 1'b0;
  endtask

  task automatic collect_results(input int total);
    int   got;
    int   cycles;
    logic finished;
    got      = 0;
    cycles   = 0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge arm_clk);
      cycles++;
      if (cycles > JOB_TIMEOUT) begin
        report_error($sformatf("timeout: no done within %0d cycles, %0d of %0d results seen",
                               JOB_TIMEOUT, got, total));
      end
      if (result_valid) begin
        if (got >= total) report_error("more result strobes than the job has results");
        check_result(result_data, expected[got], got);
        got++;
      end
      if (done) begin
        check_flag("result_valid", result_valid, 1'b0);
        check_count("result count", got, total);
        check_flag("busy", busy, 1'b0);  // falls together with done
        finished = 1'b1;
      end else begin
        check_flag("busy", busy, 1'b1);
      end
    end
  endtask

  initial begin
    int m;
    int n;
    int p;
    arm_clk    = 1'b0;
    rst        = 1'b1;
    job_valid  = 1'b0;
    job_m      = '0;
    job_n      = '0;
    job_p      = '0;
    data_valid = 1'b0;
    data_word  = '0;
    lfsr_state = 32'h8413a246;

    repeat (3) @(posedge arm_clk);
    #1;
    rst = 1'b0;

    repeat (4) begin
      @(negedge arm_clk);
      check_idle();
    end

    for (int job = 0; job < NUM_JOBS; job++) begin
      if (job == 0) begin
        m = 1;
        n = 1;
        p = 1;
      end else if (job == 1) begin
        m = 8;
        n = 8;
        p = 8;
      end else begin
        m = int'(rand_bits(3)) + 1;
        n = int'(rand_bits(3)) + 1;
        p = int'(rand_bits(3)) + 1;
      end
      start_job(m, n, p);
      load_matrices(m, n, p);
      build_expected(m, n, p);
      if (job % 3 == 2) ignored_job();
      collect_results(m * p);  // next job follows right away
    end

    @(negedge arm_clk);
    check_idle();  // done lasts a single cycle

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/mm_types_pkg.sv
src/mm_map_pkg.sv
src/shared_ram.sv
src/mem_arbiter.sv
src/host_seq.sv
src/mm_engine.sv
src/mm_sys_top.sv
bench/tb_mm_sys.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mm_sys \
  --Mdir obj_dir -f all.f

out=$(./obj_dir/Vtb_mm_sys 2>&1 || true)
echo "$out"

if grep -q "sim passed" <<< "$out"; then
  exit 0
fi
exit 1
